/* all.f */
hdl/timing_pkg.sv
hdl/scope_reg_pkg.sv
hdl/scope_capture_if.sv
hdl/tick_gen.sv
hdl/speed_control.sv
hdl/scope_sampler.sv
hdl/scope_apb_regs.sv
hdl/hex_display.sv
hdl/ipod_scope_top.sv
dv/ipod_scope_props.sv
dv/ipod_scope_tb.sv

/* dv/ipod_scope_props.sv */
`timescale 1ns/100ps

module ipod_scope_props (
  input logic CLK_50M,
  input logic rst,
  input logic ms_tick,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic arm,
  input logic busy,
  input logic done
);

  // ============================================================
  // Tick and APB rules
  // ============================================================

  // Millisecond enable is a single-cycle pulse
  a_ms_tick_single: assert property (
    @(posedge CLK_50M) disable iff (rst) ms_tick |=> !ms_tick
  ) else $error("ms_tick high for two cycles in a row");

  // No wait states in the access phase
  a_pready_access: assert property (
    @(posedge CLK_50M) disable iff (rst) (psel && penable) |-> pready
  ) else $error("pready low during an APB access phase");

  // ============================================================
  // Sampler link
  // ============================================================

  a_status_exclusive: assert property (
    @(posedge CLK_50M) disable iff (rst) !(busy && done)
  ) else $error("busy and done high together");

  a_arm_one_cycle: assert property (
    @(posedge CLK_50M) disable iff (rst) arm |=> !arm
  ) else $error("arm pulse wider than one cycle");

endmodule

/* dv/ipod_scope_tb.sv */
`timescale 1ns/100ps

module ipod_scope_tb;

  localparam int CLK_PERIOD     = 20;
  localparam int MS_CYCLES      = 20;
  localparam int UPDOWN_CYCLES  = timing_pkg::MS_PER_UPDOWN * MS_CYCLES;
  localparam int CAPTURE_CYCLES = 17 * (timing_pkg::DEFAULT_SAMPLE_COUNT + 1);
  localparam int NUM_ROWS       = 25;

  // Pressed keys as bit 0 faster, bit 1 slower and bit 2 speed reset
  localparam logic [2:0] KEY_NONE   = 3'b000;
  localparam logic [2:0] KEY_FASTER = 3'b001;
  localparam logic [2:0] KEY_SLOWER = 3'b010;
  localparam logic [2:0] KEY_BOTH   = 3'b011;
  localparam logic [2:0] KEY_RESET  = 3'b100;

  localparam logic [7:0] A_CTRL   = scope_reg_pkg::REG_CTRL;
  localparam logic [7:0] A_STATUS = scope_reg_pkg::REG_STATUS;
  localparam logic [7:0] A_CHAN_A = scope_reg_pkg::REG_CHAN_A;
  localparam logic [7:0] A_CHAN_B = scope_reg_pkg::REG_CHAN_B;
  localparam logic [7:0] A_COUNT  = scope_reg_pkg::REG_SAMPLE_COUNT;
  localparam logic [7:0] A_SPEED  = scope_reg_pkg::REG_SPEED;
  localparam logic [7:0] A_NONE   = 8'h18;

  typedef enum logic [2:0] {
    K_REG,
    K_HEX,
    K_KEYS,
    K_CAPTURE,
    K_RD_ERR,
    K_WR_ERR
  } test_kind_e;

  typedef struct packed {
    test_kind_e  kind;
    logic [2:0]  keys;
    logic [15:0] hold_ms;
    logic        probe;
    logic [7:0]  addr;
    logic [31:0] expect_val;
  } stim_row_t;

  logic                     CLK_50M;
  logic                     rst;
  logic                     key_faster_n;
  logic                     key_slower_n;
  logic                     key_speed_reset_n;
  logic                     chan_probe;
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  scope_reg_pkg::apb_addr_t paddr;
  scope_reg_pkg::apb_data_t pwdata;
  scope_reg_pkg::apb_data_t prdata;
  logic                     pready;
  logic                     pslverr;
  logic [7:0]               audio_sample;
  logic [6:0]               hex0;
  logic [6:0]               hex1;
  logic [6:0]               hex2;
  logic [6:0]               hex3;
  logic [6:0]               hex4;
  logic [6:0]               hex5;

  stim_row_t stim_rows [NUM_ROWS];
  int        error_count     = 0;
  int        check_count     = 0;
  int        failed_tests    = 0;
  int        watchdog_cycles = 0;
  integer    seed            = 32'he9bb;

  ipod_scope_top #(
    .ms_tick_cycles (MS_CYCLES)
  ) u_dut (.*);

  bind ipod_scope_top ipod_scope_props u_props (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .ms_tick (ms_tick),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .arm     (u_cap_if.arm),
    .busy    (u_cap_if.busy),
    .done    (u_cap_if.done)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #(CLK_PERIOD / 2) CLK_50M = ~CLK_50M;
  end

  // ============================================================
  // Expected values and checks
  // ============================================================

  // Standard active-high hex glyphs in gfedcba order
  function automatic logic [6:0] seg_expect(input logic [3:0] nib);
    logic [6:0] lit;
    case (nib)
      4'h0: lit = 7'b0111111;
      4'h1: lit = 7'b0000110;
      4'h2: lit = 7'b1011011;
      4'h3: lit = 7'b1001111;
      4'h4: lit = 7'b1100110;
      4'h5: lit = 7'b1101101;
      4'h6: lit = 7'b1111101;
      4'h7: lit = 7'b0000111;
      4'h8: lit = 7'b1111111;
      4'h9: lit = 7'b1101111;
      4'hA: lit = 7'b1110111;
      4'hB: lit = 7'b1111100;
      4'hC: lit = 7'b0111001;
      4'hD: lit = 7'b1011110;
      4'hE: lit = 7'b1111001;
      default: lit = 7'b1110001;
    endcase
    return ~lit;
  endfunction

  function automatic string kind_name(input test_kind_e kind);
    case (kind)
      K_REG:     return "register read";
      K_HEX:     return "hex display";
      K_KEYS:    return "speed keys";
      K_CAPTURE: return "scope capture";
      K_RD_ERR:  return "unmapped read";
      default:   return "read-only write";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  // ============================================================
  // APB accesses with both phases driven on falling edges
  // ============================================================

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic err, output logic rdy);
    @(negedge CLK_50M);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge CLK_50M);
    penable = 1'b1;
    #(CLK_PERIOD / 4);
    data = prdata;
    err  = pslverr;
    rdy  = pready;
    @(negedge CLK_50M);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic err, output logic rdy);
    @(negedge CLK_50M);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge CLK_50M);
    penable = 1'b1;
    #(CLK_PERIOD / 4);
    err = pslverr;
    rdy = pready;
    @(negedge CLK_50M);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic poll_reg(input logic [7:0] addr, input logic [31:0] mask,
                          input logic [31:0] expected, input int max_cycles, output logic ok);
    logic [31:0] data;
    logic        err;
    logic        rdy;
    int          waited;
    ok     = 1'b0;
    waited = 0;
    while (!ok && waited < max_cycles)
    begin
      apb_read(addr, data, err, rdy);
      waited += 3;
      ok = ((data & mask) == expected);
    end
    if (!ok)
    begin
      error_count++;
      $display("register 0x%02h never reached 0x%0h within %0d cycles", addr, expected,
               max_cycles);
    end
  endtask

  task automatic wait_hex(input logic [23:0] value, input int max_cycles);
    logic [41:0] exp_all;
    logic [41:0] got_all;
    int          waited;
    int          d;
    for (d = 0; d < 6; d++)
      exp_all[7*d +: 7] = seg_expect(value[4*d +: 4]);
    got_all = {hex5, hex4, hex3, hex2, hex1, hex0};
    waited  = 0;
    while (got_all != exp_all && waited < max_cycles)
    begin
      @(negedge CLK_50M);
      waited++;
      got_all = {hex5, hex4, hex3, hex2, hex1, hex0};
    end
    if (got_all != exp_all)
      $display("hex display did not show 0x%06h within %0d cycles", value, max_cycles);
    for (d = 0; d < 6; d++)
      check_value($sformatf("hex%0d", d), got_all[7*d +: 7], exp_all[7*d +: 7]);
  endtask

  task automatic press_keys(input logic [2:0] keys, input int hold_ms);
    @(negedge CLK_50M);
    key_faster_n      = ~keys[0];
    key_slower_n      = ~keys[1];
    key_speed_reset_n = ~keys[2];
    repeat (hold_ms * MS_CYCLES) @(negedge CLK_50M);
    key_faster_n      = 1'b1;
    key_slower_n      = 1'b1;
    key_speed_reset_n = 1'b1;
  endtask

  // ============================================================
  // Stimulus table
  // ============================================================

  task automatic load_table();
    stim_rows[0]  = '{K_HEX,     KEY_NONE,   16'd0,     1'b0, A_NONE,   32'h000000};
    stim_rows[1]  = '{K_REG,     KEY_NONE,   16'd0,     1'b0, A_SPEED,  32'd0};
    stim_rows[2]  = '{K_REG,     KEY_NONE,   16'd0,     1'b0, A_COUNT,  32'd12499};
    stim_rows[3]  = '{K_REG,     KEY_NONE,   16'd0,     1'b0, A_STATUS, 32'd0};
    stim_rows[4]  = '{K_HEX,     KEY_NONE,   16'd500,   1'b0, A_NONE,   32'h0030D3};
    stim_rows[5]  = '{K_KEYS,    KEY_FASTER, 16'd100,   1'b0, A_SPEED,  32'd100};
    stim_rows[6]  = '{K_KEYS,    KEY_FASTER, 16'd200,   1'b0, A_SPEED,  32'd300};
    stim_rows[7]  = '{K_KEYS,    KEY_FASTER, 16'd300,   1'b0, A_SPEED,  32'd600};
    stim_rows[8]  = '{K_KEYS,    KEY_SLOWER, 16'd200,   1'b0, A_SPEED,  32'd400};
    stim_rows[9]  = '{K_KEYS,    KEY_BOTH,   16'd100,   1'b0, A_SPEED,  32'd400};
    stim_rows[10] = '{K_KEYS,    KEY_RESET,  16'd1,     1'b0, A_SPEED,  32'd0};
    stim_rows[11] = '{K_REG,     KEY_NONE,   16'd0,     1'b0, A_COUNT,  32'd12499};
    // 121 steps up but clipped at the upper limit
    stim_rows[12] = '{K_KEYS,    KEY_FASTER, 16'd12100, 1'b0, A_SPEED,  32'd12000};
    stim_rows[13] = '{K_REG,     KEY_NONE,   16'd0,     1'b0, A_COUNT,  32'd24499};
    stim_rows[14] = '{K_HEX,     KEY_NONE,   16'd500,   1'b0, A_NONE,   32'h005FB3};
    stim_rows[15] = '{K_KEYS,    KEY_SLOWER, 16'd24100, 1'b0, A_SPEED,  32'hFFFF_D120};
    stim_rows[16] = '{K_REG,     KEY_NONE,   16'd0,     1'b0, A_COUNT,  32'd499};
    stim_rows[17] = '{K_HEX,     KEY_NONE,   16'd500,   1'b0, A_NONE,   32'h0001F3};
    stim_rows[18] = '{K_KEYS,    KEY_RESET,  16'd1,     1'b0, A_SPEED,  32'd0};
    stim_rows[19] = '{K_CAPTURE, KEY_NONE,   16'd0,     1'b1, A_CHAN_B, 32'hFFFF};
    stim_rows[20] = '{K_CAPTURE, KEY_NONE,   16'd0,     1'b0, A_CHAN_B, 32'h0000};
    stim_rows[21] = '{K_CAPTURE, KEY_NONE,   16'd0,     1'b1, A_CHAN_B, 32'hFFFF};
    stim_rows[22] = '{K_RD_ERR,  KEY_NONE,   16'd0,     1'b0, A_NONE,   32'd0};
    stim_rows[23] = '{K_WR_ERR,  KEY_NONE,   16'd0,     1'b0, A_SPEED,  32'd0};
    stim_rows[24] = '{K_HEX,     KEY_NONE,   16'd500,   1'b0, A_NONE,   32'h0030D3};
  endtask

  // Hold times, a margin per row and room for eight captures
  function automatic int watchdog_limit();
    int total;
    int i;
    total = 10 + 8 * CAPTURE_CYCLES;
    for (i = 0; i < NUM_ROWS; i++)
      total += stim_rows[i].hold_ms * MS_CYCLES + 2 * UPDOWN_CYCLES;
    return total;
  endfunction

  task automatic run_row(input int idx);
    stim_row_t                row;
    scope_reg_pkg::apb_reg_e  reg_e;
    logic [31:0]              data;
    logic                     err;
    logic                     rdy;
    logic                     ok;
    logic                     tone0;
    logic [15:0]              exp_a;
    int                       bound;
    int                       k;
    row   = stim_rows[idx];
    reg_e = scope_reg_pkg::apb_reg_e'(row.addr);
    case (row.kind)
      K_REG:
      begin
        apb_read(row.addr, data, err, rdy);
        check_value(reg_e.name(), data, row.expect_val);
        check_value("pslverr", err, 1'b0);
      end
      K_HEX:
      begin
        wait_hex(row.expect_val[23:0], row.hold_ms * MS_CYCLES + 100);
      end
      K_KEYS:
      begin
        press_keys(row.keys, row.hold_ms);
        bound = (row.hold_ms / timing_pkg::MS_PER_UPDOWN + 1) * UPDOWN_CYCLES;
        poll_reg(row.addr, 32'hFFFF_FFFF, row.expect_val, bound, ok);
        apb_read(row.addr, data, err, rdy);
        check_value(reg_e.name(), data, row.expect_val);
      end
      K_CAPTURE:
      begin
        @(negedge CLK_50M);
        chan_probe = row.probe;
        apb_write(A_CTRL, $random(seed) | 32'h1, err, rdy);
        // Tone level the sampler sees on the arm cycle
        tone0 = (audio_sample == 8'h7F);
        check_value("audio_sample", audio_sample, tone0 ? 32'h7F : 32'h80);
        check_value("pslverr", err, 1'b0);
        // Each interval spans an odd number of tone half periods
        for (k = 1; k <= scope_reg_pkg::SCOPE_SAMPLES; k++)
          exp_a[scope_reg_pkg::SCOPE_SAMPLES - k] = (k % 2 == 1) ? ~tone0 : tone0;
        poll_reg(A_STATUS, 32'h1, 32'h1, CAPTURE_CYCLES, ok);
        apb_read(A_STATUS, data, err, rdy);
        check_value("REG_STATUS", data, 32'h1);
        apb_read(A_CHAN_A, data, err, rdy);
        check_value("REG_CHAN_A", data, {16'd0, exp_a});
        apb_read(A_CHAN_B, data, err, rdy);
        check_value("REG_CHAN_B", data, row.expect_val);
      end
      K_RD_ERR:
      begin
        apb_read(row.addr, data, err, rdy);
        check_value("pslverr", err, 1'b1);
        check_value("pready", rdy, 1'b1);
      end
      default:
      begin
        apb_write(row.addr, $random(seed), err, rdy);
        check_value("pslverr", err, 1'b1);
        check_value("pready", rdy, 1'b1);
        apb_read(row.addr, data, err, rdy);
        check_value(reg_e.name(), data, row.expect_val);
      end
    endcase
  endtask

  // ============================================================
  // Main sequence and watchdog
  // ============================================================

  initial
  begin : main_seq
    int idx;
    int errs_before;
    rst               = 1'b1;
    key_faster_n      = 1'b1;
    key_slower_n      = 1'b1;
    key_speed_reset_n = 1'b1;
    chan_probe        = 1'b0;
    psel              = 1'b0;
    penable           = 1'b0;
    pwrite            = 1'b0;
    paddr             = '0;
    pwdata            = '0;
    load_table();
    watchdog_cycles = watchdog_limit();
    repeat (10) @(posedge CLK_50M);
    @(negedge CLK_50M);
    rst = 1'b0;
    for (idx = 0; idx < NUM_ROWS; idx++)
    begin
      errs_before = error_count;
      run_row(idx);
      if (error_count == errs_before)
        $display("test %0d %s: ok", idx, kind_name(stim_rows[idx].kind));
      else
      begin
        failed_tests++;
        $display("test %0d %s: failed", idx, kind_name(stim_rows[idx].kind));
      end
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors", NUM_ROWS, failed_tests,
             check_count, error_count);
    if (error_count == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  initial
  begin : watchdog
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge CLK_50M);
    $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* hdl/hex_display.sv */
`timescale 1ns/100ps

module hex_display (
  input  logic               CLK_50M,
  input  logic               rst,
  input  logic               display_tick,
  input  timing_pkg::count_t sample_count,
  output logic [6:0]         hex0,
  output logic [6:0]         hex1,
  output logic [6:0]         hex2,
  output logic [6:0]         hex3,
  output logic [6:0]         hex4,
  output logic [6:0]         hex5
);

  logic [23:0] shown;

  // Active-low segments, gfedcba
  function automatic logic [6:0] seg_decode(input logic [3:0] nib);
    case (nib)
      4'h0: seg_decode = 7'h40;
      4'h1: seg_decode = 7'h79;
      4'h2: seg_decode = 7'h24;
      4'h3: seg_decode = 7'h30;
      4'h4: seg_decode = 7'h19;
      4'h5: seg_decode = 7'h12;
      4'h6: seg_decode = 7'h02;
      4'h7: seg_decode = 7'h78;
      4'h8: seg_decode = 7'h00;
      4'h9: seg_decode = 7'h10;
      4'hA: seg_decode = 7'h08;
      4'hB: seg_decode = 7'h03;
      4'hC: seg_decode = 7'h46;
      4'hD: seg_decode = 7'h21;
      4'hE: seg_decode = 7'h06;
      default: seg_decode = 7'h0E;
    endcase
  endfunction

  // Snapshot once per refresh so the digits stay readable
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      shown <= '0;
    else if (display_tick)
      shown <= {8'd0, sample_count};
  end

  assign hex0 = seg_decode(shown[3:0]);
  assign hex1 = seg_decode(shown[7:4]);
  assign hex2 = seg_decode(shown[11:8]);
  assign hex3 = seg_decode(shown[15:12]);
  assign hex4 = seg_decode(shown[19:16]);
  assign hex5 = seg_decode(shown[23:20]);

endmodule

/* hdl/ipod_scope_top.sv */
`timescale 1ns/100ps

module ipod_scope_top #(
  parameter int ms_tick_cycles = timing_pkg::MS_TICK_CYCLES
) (
  input  logic                     CLK_50M,
  input  logic                     rst,
  input  logic                     key_faster_n,
  input  logic                     key_slower_n,
  input  logic                     key_speed_reset_n,
  input  logic                     chan_probe,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  scope_reg_pkg::apb_addr_t paddr,
  input  scope_reg_pkg::apb_data_t pwdata,
  output scope_reg_pkg::apb_data_t prdata,
  output logic                     pready,
  output logic                     pslverr,
  output logic [7:0]               audio_sample,
  output logic [6:0]               hex0,
  output logic [6:0]               hex1,
  output logic [6:0]               hex2,
  output logic [6:0]               hex3,
  output logic [6:0]               hex4,
  output logic [6:0]               hex5
);

  logic               ms_tick;
  logic               display_tick;
  logic               tone;
  timing_pkg::speed_t speed;
  timing_pkg::count_t sample_count;

  // Sampler to register block link
  scope_capture_if u_cap_if ();

  tick_gen #(
    .ms_tick_cycles (ms_tick_cycles)
  ) u_tick_gen (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .ms_tick      (ms_tick),
    .display_tick (display_tick),
    .tone         (tone),
    .audio_sample (audio_sample)
  );

  speed_control u_speed_control (
    .CLK_50M           (CLK_50M),
    .rst               (rst),
    .ms_tick           (ms_tick),
    .key_faster_n      (key_faster_n),
    .key_slower_n      (key_slower_n),
    .key_speed_reset_n (key_speed_reset_n),
    .speed             (speed),
    .sample_count      (sample_count)
  );

  scope_sampler u_scope_sampler (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .sample_count (sample_count),
    .tone         (tone),
    .chan_probe   (chan_probe),
    .cap          (u_cap_if.sampler)
  );

  scope_apb_regs u_scope_apb_regs (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .speed        (speed),
    .sample_count (sample_count),
    .cap          (u_cap_if.regs),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr)
  );

  hex_display u_hex_display (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .display_tick (display_tick),
    .sample_count (sample_count),
    .hex0         (hex0),
    .hex1         (hex1),
    .hex2         (hex2),
    .hex3         (hex3),
    .hex4         (hex4),
    .hex5         (hex5)
  );

endmodule

/* hdl/scope_apb_regs.sv */
`timescale 1ns/100ps

module scope_apb_regs (
  input  logic                     CLK_50M,
  input  logic                     rst,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  scope_reg_pkg::apb_addr_t paddr,
  input  scope_reg_pkg::apb_data_t pwdata,
  input  timing_pkg::speed_t       speed,
  input  timing_pkg::count_t       sample_count,
  scope_capture_if.regs            cap,
  output scope_reg_pkg::apb_data_t prdata,
  output logic                     pready,
  output logic                     pslverr
);

  logic mapped;
  logic is_ctrl;
  logic access;

  assign access = psel && penable;

  // ============================================================
  // Address decode and read mux
  // ============================================================

  always_comb
  begin
    mapped  = 1'b1;
    is_ctrl = 1'b0;
    prdata  = '0;
    case (scope_reg_pkg::apb_reg_e'(paddr))
      scope_reg_pkg::REG_CTRL:         is_ctrl = 1'b1;
      scope_reg_pkg::REG_STATUS:       prdata = {30'd0, cap.busy, cap.done};
      scope_reg_pkg::REG_CHAN_A:       prdata = {16'd0, cap.chan_a};
      scope_reg_pkg::REG_CHAN_B:       prdata = {16'd0, cap.chan_b};
      scope_reg_pkg::REG_SAMPLE_COUNT: prdata = {16'd0, sample_count};
      // Offset goes out sign-extended
      scope_reg_pkg::REG_SPEED:        prdata = {{16{speed[15]}}, speed};
      default:                         mapped = 1'b0;
    endcase
  end

  // No wait states
  assign pready = 1'b1;

  // Only the control register is writable
  assign pslverr = access && (!mapped || (pwrite && !is_ctrl));

  // ============================================================
  // Arm pulse
  // ============================================================

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      cap.arm <= 1'b0;
    else
      cap.arm <= access && pwrite && is_ctrl && pwdata[0];
  end

endmodule

/* hdl/scope_capture_if.sv */
`timescale 1ns/100ps

interface scope_capture_if;

  // One-cycle start pulse from the register block
  logic                      arm;
  logic                      busy;
  logic                      done;
  scope_reg_pkg::chan_word_t chan_a;
  scope_reg_pkg::chan_word_t chan_b;

  modport sampler (
    input  arm,
    output busy, done, chan_a, chan_b
  );

  modport regs (
    output arm,
    input  busy, done, chan_a, chan_b
  );

endinterface

/* hdl/scope_reg_pkg.sv */
package scope_reg_pkg;

  // ============================================================
  // Capture sizes
  // ============================================================

  localparam int SCOPE_SAMPLES = 16;

  typedef logic [15:0] chan_word_t;

  // ============================================================
  // APB register map
  // ============================================================

  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  typedef enum logic [7:0] {
    REG_CTRL         = 8'h00,
    REG_STATUS       = 8'h04,
    REG_CHAN_A       = 8'h08,
    REG_CHAN_B       = 8'h0C,
    REG_SAMPLE_COUNT = 8'h10,
    REG_SPEED        = 8'h14
  } apb_reg_e;

  // Sampler FSM
  typedef enum logic [1:0] {
    SMP_IDLE,
    SMP_CAPTURE,
    SMP_DONE
  } sampler_state_e;

endpackage

/* hdl/scope_sampler.sv */
`timescale 1ns/100ps

module scope_sampler (
  input  logic                 CLK_50M,
  input  logic                 rst,
  input  timing_pkg::count_t   sample_count,
  input  logic                 tone,
  input  logic                 chan_probe,
  scope_capture_if.sampler     cap
);

  localparam int SMP_W = $clog2(scope_reg_pkg::SCOPE_SAMPLES);

  scope_reg_pkg::sampler_state_e state;
  timing_pkg::count_t            ivl_cnt;
  logic [SMP_W-1:0]              smp_cnt;

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      state      <= scope_reg_pkg::SMP_IDLE;
      ivl_cnt    <= '0;
      smp_cnt    <= '0;
      cap.chan_a <= '0;
      cap.chan_b <= '0;
    end
    else if (cap.arm)
    begin
      // Arm restarts from scratch, even mid-capture
      state      <= scope_reg_pkg::SMP_CAPTURE;
      ivl_cnt    <= sample_count;
      smp_cnt    <= '0;
      cap.chan_a <= '0;
      cap.chan_b <= '0;
    end
    else if (state == scope_reg_pkg::SMP_CAPTURE)
    begin
      if (ivl_cnt == '0)
      begin
        cap.chan_a <= {cap.chan_a[14:0], tone};
        cap.chan_b <= {cap.chan_b[14:0], chan_probe};
        ivl_cnt    <= sample_count;
        smp_cnt    <= smp_cnt + 1'b1;
        if (smp_cnt == SMP_W'(scope_reg_pkg::SCOPE_SAMPLES - 1))
          state <= scope_reg_pkg::SMP_DONE;
      end
      else
      begin
        ivl_cnt <= ivl_cnt - 1'b1;
      end
    end
  end

  // Status straight from the state register
  assign cap.busy = (state == scope_reg_pkg::SMP_CAPTURE);
  assign cap.done = (state == scope_reg_pkg::SMP_DONE);

endmodule

/* hdl/speed_control.sv */
`timescale 1ns/100ps

module speed_control (
  input  logic                CLK_50M,
  input  logic                rst,
  input  logic                ms_tick,
  input  logic                key_faster_n,
  input  logic                key_slower_n,
  input  logic                key_speed_reset_n,
  output timing_pkg::speed_t  speed,
  output timing_pkg::count_t  sample_count
);

  localparam int UPDN_W = $clog2(timing_pkg::MS_PER_UPDOWN);

  logic [2:0]          key_meta;
  logic [2:0]          key_sync;
  logic                faster_held;
  logic                slower_held;
  logic                reset_held;
  logic [UPDN_W-1:0]   updn_cnt;
  logic                step_tick;
  timing_pkg::speed_t  speed_inc;
  timing_pkg::speed_t  speed_dec;

  // Two-flop synchronizers, keys idle high
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      key_meta <= 3'b111;
      key_sync <= 3'b111;
    end
    else
    begin
      key_meta <= {key_speed_reset_n, key_slower_n, key_faster_n};
      key_sync <= key_meta;
    end
  end

  assign faster_held = ~key_sync[0];
  assign slower_held = ~key_sync[1];
  assign reset_held  = ~key_sync[2];

  // Rate limiter, one step opportunity per MS_PER_UPDOWN ticks
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      updn_cnt <= '0;
    else if (ms_tick)
      updn_cnt <= step_tick ? '0 : updn_cnt + 1'b1;
  end

  assign step_tick = ms_tick && (updn_cnt == UPDN_W'(timing_pkg::MS_PER_UPDOWN - 1));

  assign speed_inc = speed + timing_pkg::speed_t'(timing_pkg::SPEED_STEP);
  assign speed_dec = speed - timing_pkg::speed_t'(timing_pkg::SPEED_STEP);

  // Saturating offset, reset key wins
  always_ff @(posedge CLK_50M)
  begin
    if (rst || reset_held)
      speed <= '0;
    else if (step_tick && faster_held && !slower_held)
      speed <= (speed_inc > timing_pkg::speed_t'(timing_pkg::SPEED_MAX)) ?
               timing_pkg::speed_t'(timing_pkg::SPEED_MAX) : speed_inc;
    else if (step_tick && slower_held && !faster_held)
      speed <= (speed_dec < timing_pkg::speed_t'(timing_pkg::SPEED_MIN)) ?
               timing_pkg::speed_t'(timing_pkg::SPEED_MIN) : speed_dec;
  end

  // Sampling count follows the offset by one cycle
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      sample_count <= timing_pkg::count_t'(timing_pkg::DEFAULT_SAMPLE_COUNT);
    else
      sample_count <= timing_pkg::count_t'(timing_pkg::DEFAULT_SAMPLE_COUNT)
                      + timing_pkg::count_t'(speed);
  end

endmodule

/* hdl/tick_gen.sv */
`timescale 1ns/100ps

module tick_gen #(
  parameter int ms_tick_cycles = 50000
) (
  input  logic       CLK_50M,
  input  logic       rst,
  output logic       ms_tick,
  output logic       display_tick,
  output logic       tone,
  output logic [7:0] audio_sample
);

  localparam int CYC_W = $clog2(ms_tick_cycles);
  localparam int MS_W  = $clog2(timing_pkg::MS_PER_DISPLAY);

  logic [CYC_W-1:0] cyc_cnt;
  logic [MS_W-1:0]  ms_cnt;

  // Millisecond enable from the system clock
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      cyc_cnt <= '0;
      ms_tick <= 1'b0;
    end
    else if (cyc_cnt == CYC_W'(ms_tick_cycles - 1))
    begin
      cyc_cnt <= '0;
      ms_tick <= 1'b1;
    end
    else
    begin
      cyc_cnt <= cyc_cnt + 1'b1;
      ms_tick <= 1'b0;
    end
  end

  // Display refresh enable and square-wave tone
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      ms_cnt       <= '0;
      display_tick <= 1'b0;
      tone         <= 1'b0;
    end
    else
    begin
      display_tick <= 1'b0;
      if (ms_tick)
      begin
        tone <= ~tone;
        if (ms_cnt == MS_W'(timing_pkg::MS_PER_DISPLAY - 1))
        begin
          ms_cnt       <= '0;
          display_tick <= 1'b1;
        end
        else
        begin
          ms_cnt <= ms_cnt + 1'b1;
        end
      end
    end
  end

  // Signed full-scale sample, 0x7F high and 0x80 low
  assign audio_sample = {~tone, {7{tone}}};

endmodule

/* hdl/timing_pkg.sv */
package timing_pkg;

  // ============================================================
  // Clock and tick rates
  // ============================================================

  localparam int CLK_HZ         = 50_000_000;
  localparam int MS_TICK_CYCLES = CLK_HZ / 1000;

  // Milliseconds between accepted faster or slower steps
  localparam int MS_PER_UPDOWN  = 100;

  // Display refresh period in milliseconds
  localparam int MS_PER_DISPLAY = 500;

  // ============================================================
  // Speed offset and sampling count
  // ============================================================

  localparam int SPEED_STEP = 100;
  localparam int SPEED_MIN  = -12000;
  localparam int SPEED_MAX  = 12000;

  // Sampling count with zero offset
  localparam int DEFAULT_SAMPLE_COUNT = 12499;

  typedef logic signed [15:0] speed_t;
  typedef logic [15:0]        count_t;

endpackage
